/* decode_pkg.sv */
// shared types for the decode stage; opcodes 00010, 00011 and 11010 are left undefined
`default_nettype none

package decode_pkg;

   // widths with a meaning of their own
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [1:0]  wb_sel_t;
   typedef logic [1:0]  alu_src_t;
   typedef logic [2:0]  alu_res_t;
   typedef logic [4:0]  alu_op_t;
   typedef logic [1:0]  op_ext_t;

   localparam int       num_regs = 8;
   localparam reg_idx_t link_reg = reg_idx_t'(7);

   // write-back source select
   localparam wb_sel_t wb_alu = 2'd0;
   localparam wb_sel_t wb_mem = 2'd1;
   localparam wb_sel_t wb_pc  = 2'd2;
   localparam wb_sel_t wb_imm = 2'd3;

   // second alu operand
   localparam alu_src_t src_reg = 2'd0;
   localparam alu_src_t src_imm = 2'd1;

   // result mux in execute
   localparam alu_res_t res_alu  = 3'd0;
   localparam alu_res_t res_seq  = 3'd1;
   localparam alu_res_t res_slt  = 3'd2;
   localparam alu_res_t res_sle  = 3'd3;
   localparam alu_res_t res_sco  = 3'd4;
   localparam alu_res_t res_slbi = 3'd5;

   typedef enum logic [4:0] {
      halt   = 5'b00000,
      nop    = 5'b00001,
      j      = 5'b00100,
      jr     = 5'b00101,
      jal    = 5'b00110,
      jalr   = 5'b00111,
      addi   = 5'b01000,
      subi   = 5'b01001,
      xori   = 5'b01010,
      andni  = 5'b01011,
      beqz   = 5'b01100,
      bnez   = 5'b01101,
      bltz   = 5'b01110,
      bgez   = 5'b01111,
      st     = 5'b10000,
      ld     = 5'b10001,
      slbi   = 5'b10010,
      stu    = 5'b10011,
      roli   = 5'b10100,
      slli   = 5'b10101,
      rori   = 5'b10110,
      srli   = 5'b10111,
      lbi    = 5'b11000,
      alu_sh = 5'b11001,
      alu_rr = 5'b11011,
      seq    = 5'b11100,
      slt    = 5'b11101,
      sle    = 5'b11110,
      sco    = 5'b11111
   } opcode_t;

   typedef enum logic [2:0] {
      imm5_zext,
      imm5_sext,
      imm8_zext,
      imm8_sext,
      disp11_sext
   } imm_kind_t;

   // low two opcode bits of the branches map straight onto this
   typedef enum logic [1:0] {
      cond_zero    = 2'b00,
      cond_nonzero = 2'b01,
      cond_neg     = 2'b10,
      cond_not_neg = 2'b11
   } cond_t;

   typedef struct packed {
      logic     halt;
      wb_sel_t  wb_sel;
      alu_src_t alu_src;
      alu_res_t alu_result;
      alu_op_t  alu_op;
      logic     mem_read;
      logic     mem_wrt;
      logic     reg_wrt;
      reg_idx_t target_reg;
      op_ext_t  op_ext;
   } ctrl_t;

   typedef struct packed {
      logic  branch;
      cond_t cond;
      logic  jump_pc_rel;
      logic  jump_reg;
   } br_ctrl_t;

   typedef struct packed {
      logic     reg_wrt;
      reg_idx_t target_reg;
      word_t    data;
   } wb_port_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
// opcode decode is combinational; an all-zero instruction acts as nop until a nonzero opcode precedes it
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
   input  logic                 clk,
   input  logic                 arst_n,
   input  decode_pkg::word_t    instr,
   input  logic                 halt_back,
   output decode_pkg::ctrl_t    ctrl,
   output decode_pkg::br_ctrl_t br,
   output decode_pkg::word_t    imm,
   output logic                 err
);
   import decode_pkg::*;

   opcode_t   op_raw;
   opcode_t   prev_op;
   opcode_t   op;
   logic      seen;
   imm_kind_t kind;

   assign op_raw = opcode_t'(instr[15:11]);

   // previous opcode, zero after reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prev_op <= halt;
      end else begin
         prev_op <= op_raw;
      end
   end

   // zero instr with zero history is treated as a bubble
   assign seen = (prev_op != halt) || (op_raw != halt);
   assign op   = seen ? op_raw : nop;

   always_comb begin
      ctrl            = '0;
      ctrl.wb_sel     = wb_alu;
      ctrl.alu_src    = src_reg;
      ctrl.alu_result = res_alu;
      ctrl.alu_op     = alu_op_t'(op);
      ctrl.op_ext     = instr[1:0];
      ctrl.target_reg = instr[4:2];
      br              = '0;
      br.cond         = cond_t'(instr[12:11]);
      kind            = imm5_zext;
      err             = 1'b0;

      case (op)
         halt: ctrl.halt = ~halt_back;
         nop: ;
         addi, subi: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_src    = src_imm;
            ctrl.target_reg = instr[7:5];
            kind            = imm5_sext;
         end
         xori, andni, roli, slli, rori, srli: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_src    = src_imm;
            ctrl.target_reg = instr[7:5];
         end
         st: begin
            ctrl.mem_wrt = 1'b1;
            ctrl.alu_src = src_imm;
            kind         = imm5_sext;
         end
         ld: begin
            ctrl.mem_read   = 1'b1;
            ctrl.reg_wrt    = 1'b1;
            ctrl.wb_sel     = wb_mem;
            ctrl.alu_src    = src_imm;
            ctrl.target_reg = instr[7:5];
            kind            = imm5_sext;
         end
         // store with the address written back to rs
         stu: begin
            ctrl.mem_wrt    = 1'b1;
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_src    = src_imm;
            ctrl.target_reg = instr[10:8];
            kind            = imm5_sext;
         end
         beqz, bnez, bltz, bgez: begin
            br.branch = 1'b1;
            kind      = imm8_sext;
         end
         lbi: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.wb_sel     = wb_imm;
            ctrl.target_reg = instr[10:8];
            kind            = imm8_sext;
         end
         slbi: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_src    = src_imm;
            ctrl.alu_result = res_slbi;
            ctrl.target_reg = instr[10:8];
            kind            = imm8_zext;
         end
         j: begin
            br.jump_pc_rel = 1'b1;
            kind           = disp11_sext;
         end
         jal: begin
            br.jump_pc_rel  = 1'b1;
            ctrl.reg_wrt    = 1'b1;
            ctrl.wb_sel     = wb_pc;
            ctrl.target_reg = link_reg;
            kind            = disp11_sext;
         end
         jr: begin
            br.jump_reg = 1'b1;
            kind        = imm8_sext;
         end
         jalr: begin
            br.jump_reg     = 1'b1;
            ctrl.reg_wrt    = 1'b1;
            ctrl.wb_sel     = wb_pc;
            ctrl.target_reg = link_reg;
            kind            = imm8_sext;
         end
         alu_rr, alu_sh: ctrl.reg_wrt = 1'b1;
         seq: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_result = res_seq;
         end
         slt: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_result = res_slt;
         end
         sle: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_result = res_sle;
         end
         sco: begin
            ctrl.reg_wrt    = 1'b1;
            ctrl.alu_result = res_sco;
         end
         // undefined opcode, nothing may change state
         default: err = 1'b1;
      endcase
   end

   // immediate extension
   always_comb begin
      case (kind)
         imm5_sext:   imm = {{11{instr[4]}}, instr[4:0]};
         imm8_zext:   imm = {8'b0, instr[7:0]};
         imm8_sext:   imm = {{8{instr[7]}}, instr[7:0]};
         disp11_sext: imm = {{5{instr[10]}}, instr[10:0]};
         default:     imm = {11'b0, instr[4:0]};
      endcase
   end

endmodule

`default_nettype wire

/* reg_file.sv */
// write lands on the rising clk edge; a same-cycle read of the written index sees the new data
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                 clk,
   input  logic                 arst_n,
   input  decode_pkg::reg_idx_t rd_idx1,
   input  decode_pkg::reg_idx_t rd_idx2,
   input  decode_pkg::wb_port_t wb,
   output decode_pkg::word_t    data1,
   output decode_pkg::word_t    data2
);
   import decode_pkg::*;

   word_t regs [num_regs];

   // one read port with write-through bypass
   function automatic word_t bypass_read(
      input reg_idx_t idx,
      input word_t    stored,
      input wb_port_t w
   );
      word_t result;
      if (w.reg_wrt && (w.target_reg == idx)) begin
         result = w.data;
      end else begin
         result = stored;
      end
      return result;
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.reg_wrt) begin
         regs[wb.target_reg] <= wb.data;
      end
   end

   assign data1 = bypass_read(rd_idx1, regs[rd_idx1], wb);
   assign data2 = bypass_read(rd_idx2, regs[rd_idx2], wb);

endmodule

`default_nettype wire

/* branch_unit.sv */
// purely combinational; branch conditions test data1 only and sums wrap at 16 bits
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
   input  decode_pkg::br_ctrl_t br,
   input  decode_pkg::word_t    imm,
   input  decode_pkg::word_t    data1,
   input  decode_pkg::word_t    pc_next,
   output decode_pkg::word_t    pc_back,
   output logic                 redirect
);
   import decode_pkg::*;

   logic  zero;
   logic  neg;
   logic  cond_hold;
   logic  taken;
   word_t pc_rel_target;
   word_t reg_target;

   // flags from the register operand
   assign zero = (data1 == '0);
   assign neg  = data1[15];

   always_comb begin
      case (br.cond)
         cond_zero:    cond_hold = zero;
         cond_nonzero: cond_hold = ~zero;
         cond_neg:     cond_hold = neg;
         cond_not_neg: cond_hold = ~neg;
         default:      cond_hold = 1'b0;
      endcase
   end

   assign taken = br.branch & cond_hold;

   // two target adders
   assign pc_rel_target = pc_next + imm;
   assign reg_target    = data1 + imm;

   assign redirect = taken | br.jump_pc_rel | br.jump_reg;

   always_comb begin
      if (taken || br.jump_pc_rel) begin
         pc_back = pc_rel_target;
      end else if (br.jump_reg) begin
         pc_back = reg_target;
      end else begin
         pc_back = pc_next;
      end
   end

endmodule

`default_nettype wire

/* decode_stage.sv */
// no valid or ready; a new instr is accepted every cycle and hazards between stages are not checked
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                 clk,
   input  logic                 arst_n,
   input  decode_pkg::word_t    instr,
   input  decode_pkg::word_t    pc_next,
   input  logic                 halt_back,
   input  decode_pkg::wb_port_t wb,
   output decode_pkg::ctrl_t    ctrl,
   output decode_pkg::word_t    imm,
   output decode_pkg::word_t    data1,
   output decode_pkg::word_t    data2,
   output decode_pkg::word_t    pc_back,
   output logic                 redirect,
   output logic                 err
);
   import decode_pkg::*;

   br_ctrl_t br;

   // control decode and immediate
   instr_decoder u_instr_decoder (
      .clk       (clk),
      .arst_n    (arst_n),
      .instr     (instr),
      .halt_back (halt_back),
      .ctrl      (ctrl),
      .br        (br),
      .imm       (imm),
      .err       (err)
   );

   // rs on port 1, rt on port 2
   reg_file u_reg_file (
      .clk     (clk),
      .arst_n  (arst_n),
      .rd_idx1 (instr[10:8]),
      .rd_idx2 (instr[7:5]),
      .wb      (wb),
      .data1   (data1),
      .data2   (data2)
   );

   // redirect back to fetch
   branch_unit u_branch_unit (
      .br       (br),
      .imm      (imm),
      .data1    (data1),
      .pc_next  (pc_next),
      .pc_back  (pc_back),
      .redirect (redirect)
   );

endmodule

`default_nettype wire

/* tb_decode_model.svh */
// reference model of the decode rules; include after importing decode_pkg inside a module
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

typedef struct packed {
   logic     halt;
   logic     mem_read;
   logic     mem_wrt;
   logic     reg_wrt;
   reg_idx_t target_reg;
   logic     err;
   logic     redirect;
   word_t    imm;
   word_t    data1;
   word_t    data2;
   word_t    pc_back;
} expect_t;

// low field of a given width, zero or sign extended
function automatic word_t extend(word_t field, int bits, bit sign);
   int value;
   value = int'(field) % (1 << bits);
   if (sign && value >= (1 << (bits - 1))) begin
      value = value - (1 << bits);
   end
   return word_t'(value);
endfunction

function automatic word_t ref_imm(word_t ins);
   case (opcode_t'(ins[15:11]))
      addi, subi, st, ld, stu: return extend(ins, 5, 1'b1);
      slbi: return extend(ins, 8, 1'b0);
      lbi, beqz, bnez, bltz, bgez, jr, jalr: return extend(ins, 8, 1'b1);
      j, jal: return extend(ins, 11, 1'b1);
      default: return extend(ins, 5, 1'b0);
   endcase
endfunction

function automatic logic branch_taken(opcode_t op, word_t d1);
   case (op)
      beqz: return d1 == 16'd0;
      bnez: return d1 != 16'd0;
      bltz: return d1[15];
      bgez: return !d1[15];
      default: return 1'b0;
   endcase
endfunction

// primed means the previous opcode was nonzero
function automatic expect_t predict(word_t ins, word_t pcn, logic hb, logic primed,
                                    word_t d1, word_t d2);
   expect_t e;
   opcode_t op;
   op        = opcode_t'(ins[15:11]);
   e         = '0;
   e.imm     = ref_imm(ins);
   e.data1   = d1;
   e.data2   = d2;
   e.pc_back = pcn;
   e.err     = ins[15:11] inside {5'b00010, 5'b00011, 5'b11010};
   case (op)
      halt: e.halt = primed && !hb;
      st: e.mem_wrt = 1'b1;
      ld: {e.mem_read, e.reg_wrt, e.target_reg} = {2'b11, ins[7:5]};
      stu: {e.mem_wrt, e.reg_wrt, e.target_reg} = {2'b11, ins[10:8]};
      addi, subi, xori, andni, roli, slli, rori, srli: {e.reg_wrt, e.target_reg} = {1'b1, ins[7:5]};
      lbi, slbi: {e.reg_wrt, e.target_reg} = {1'b1, ins[10:8]};
      alu_rr, alu_sh, seq, slt, sle, sco: {e.reg_wrt, e.target_reg} = {1'b1, ins[4:2]};
      jal, jalr: {e.reg_wrt, e.target_reg} = {1'b1, link_reg};
      default: ;
   endcase
   if (op inside {j, jal} || branch_taken(op, d1)) begin
      e.redirect = 1'b1;
      e.pc_back  = pcn + e.imm;
   end else if (op inside {jr, jalr}) begin
      e.redirect = 1'b1;
      e.pc_back  = d1 + e.imm;
   end
   return e;
endfunction

`endif

/* tb_decode_stage.sv */
// drives fetch and write-back from the testbench; hazards between stages are not exercised
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
   import decode_pkg::*;
   `include "tb_decode_model.svh"

   // reset, six tests with one idle cycle each, and all stimulus steps
   localparam int stim_cycles = 10 + 2 + 24 + 48 + 27 + 32 + 18 + 6;
   localparam int cycle_limit = 2 * stim_cycles;

   logic     clk;
   logic     arst_n;
   word_t    instr;
   word_t    pc_next;
   logic     halt_back;
   wb_port_t wb;
   ctrl_t    ctrl;
   word_t    imm;
   word_t    data1;
   word_t    data2;
   word_t    pc_back;
   logic     redirect;
   logic     err;

   word_t       shadow [num_regs];
   expect_t     want;
   logic        armed;
   logic        primed;
   logic [31:0] rng = 32'h85cf;
   int          checks = 0;
   int          errors = 0;
   int          tests = 0;
   int          err_at_start = 0;
   int          cycles = 0;
   opcode_t     imm_ops [6] = '{addi, andni, lbi, slbi, beqz, j};
   opcode_t     br_ops [4] = '{beqz, bnez, bltz, bgez};
   opcode_t     jmp_ops [4] = '{j, jal, jr, jalr};
   logic [4:0]  bad_ops [3] = '{5'b00010, 5'b00011, 5'b11010};

   decode_stage DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .instr     (instr),
      .pc_next   (pc_next),
      .halt_back (halt_back),
      .wb        (wb),
      .ctrl      (ctrl),
      .imm       (imm),
      .data1     (data1),
      .data2     (data2),
      .pc_back   (pc_back),
      .redirect  (redirect),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng[15:0];
   endfunction

   function automatic word_t make_instr(opcode_t op, logic [10:0] low);
      return {op, low};
   endfunction

   function automatic wb_port_t wb_write(reg_idx_t idx, word_t value);
      wb_port_t w;
      w.reg_wrt    = 1'b1;
      w.target_reg = idx;
      w.data       = value;
      return w;
   endfunction

   // one instruction per falling edge with its expectation for the next rising edge
   task automatic step(input word_t ins, input word_t pcn, input logic hb, input wb_port_t w);
      word_t d1;
      word_t d2;
      @(negedge clk);
      instr     = ins;
      pc_next   = pcn;
      halt_back = hb;
      wb        = w;
      d1 = (w.reg_wrt && w.target_reg == ins[10:8]) ? w.data : shadow[ins[10:8]];
      d2 = (w.reg_wrt && w.target_reg == ins[7:5]) ? w.data : shadow[ins[7:5]];
      want  = predict(ins, pcn, hb, primed, d1, d2);
      armed = 1'b1;
      if (w.reg_wrt) begin
         shadow[w.target_reg] = w.data;
      end
      primed = (ins[15:11] != 5'd0);
   endtask

   task automatic start_test();
      err_at_start = errors;
   endtask

   task automatic report_test(input string name);
      @(negedge clk);
      armed = 1'b0;
      wb    = '0;
      tests++;
      if (errors == err_at_start) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: %0d mismatches", name, errors - err_at_start);
      end
   endtask

   task automatic check_value(input string name, input word_t exp_v, input word_t act_v);
      checks++;
      assert (act_v === exp_v) else begin
         $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      if (armed) begin
         check_value("ctrl.halt", want.halt, ctrl.halt);
         check_value("ctrl.mem_read", want.mem_read, ctrl.mem_read);
         check_value("ctrl.mem_wrt", want.mem_wrt, ctrl.mem_wrt);
         check_value("ctrl.reg_wrt", want.reg_wrt, ctrl.reg_wrt);
         if (want.reg_wrt) begin
            check_value("ctrl.target_reg", want.target_reg, ctrl.target_reg);
         end
         check_value("err", want.err, err);
         check_value("redirect", want.redirect, redirect);
         check_value("imm", want.imm, imm);
         check_value("data1", want.data1, data1);
         check_value("data2", want.data2, data2);
         check_value("pc_back", want.pc_back, pc_back);
      end
   end

   initial begin
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int i;
      int k;
      int r;
      int n;
      arst_n    = 1'b0;
      instr     = '0;
      pc_next   = '0;
      halt_back = 1'b0;
      wb        = '0;
      armed     = 1'b0;
      primed    = 1'b0;
      for (i = 0; i < num_regs; i++) begin
         shadow[i] = '0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // zero instruction with no history stays a bubble
      start_test();
      step(16'h0000, next_rand(), 1'b0, '0);
      step(16'h0000, next_rand(), 1'b0, '0);
      report_test("reset_halt");

      start_test();
      for (i = 0; i < num_regs; i++) begin
         step(make_instr(nop, 11'd0), next_rand(), 1'b0, wb_write(reg_idx_t'(i), next_rand()));
      end
      for (i = 0; i < num_regs; i++) begin
         step(make_instr(nop, {3'(i), 3'(7 - i), 5'd0}), next_rand(), 1'b0, '0);
      end
      // same index written and read in one cycle
      for (i = 0; i < num_regs; i++) begin
         step(make_instr(nop, {3'(i), 3'(i), 5'd0}), next_rand(), 1'b0,
              wb_write(reg_idx_t'(i), next_rand()));
      end
      report_test("reg_rw");

      start_test();
      for (k = 0; k < 6; k++) begin
         for (n = 0; n < 8; n++) begin
            step(make_instr(imm_ops[k], 11'(next_rand())), next_rand(), 1'b0, '0);
         end
      end
      report_test("imm_ext");

      // r0 zero, r1 positive, r2 negative
      start_test();
      step(make_instr(nop, 11'd0), next_rand(), 1'b0, wb_write(3'd0, 16'd0));
      step(make_instr(nop, 11'd0), next_rand(), 1'b0,
           wb_write(3'd1, (next_rand() & 16'h7fff) | 16'd1));
      step(make_instr(nop, 11'd0), next_rand(), 1'b0, wb_write(3'd2, next_rand() | 16'h8000));
      for (k = 0; k < 4; k++) begin
         for (r = 0; r < 3; r++) begin
            for (n = 0; n < 2; n++) begin
               step(make_instr(br_ops[k], {3'(r), 8'(next_rand())}), next_rand(), 1'b0, '0);
            end
         end
      end
      report_test("branch");

      start_test();
      for (k = 0; k < 4; k++) begin
         for (n = 0; n < 8; n++) begin
            step(make_instr(jmp_ops[k], 11'(next_rand())), next_rand(), 1'b0, '0);
         end
      end
      report_test("jump");

      start_test();
      for (k = 0; k < 3; k++) begin
         for (n = 0; n < 4; n++) begin
            step({bad_ops[k], 11'(next_rand())}, next_rand(), 1'(next_rand()), '0);
         end
      end
      step(make_instr(nop, 11'd0), next_rand(), 1'b0, '0);
      step(16'h0000, next_rand(), 1'b0, '0);
      step(make_instr(nop, 11'd0), next_rand(), 1'b0, '0);
      step(16'h0000, next_rand(), 1'b1, '0);
      step(make_instr(addi, 11'(next_rand())), next_rand(), 1'b0, '0);
      step(16'h0000, next_rand(), 1'b0, '0);
      report_test("err_halt");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* decode_stage.f */
+incdir+.
decode_pkg.sv
instr_decoder.sv
reg_file.sv
branch_unit.sv
decode_stage.sv
tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - instr_decoder.sv
  - reg_file.sv
  - branch_unit.sv
  - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv
